// File: bench/hih_sensor_model.sv
/* behavioral i2c slave for the humidity sensor, returns a given frame
   or refuses its address */
`timescale 1ns/100ps

module hih_sensor_model #(
	parameter logic [6:0] address = 7'h27
) (
	input  logic clock,
	input  logic scl,
	input  logic sda_out,
	input  logic sda_oe,
	output logic sda_in,
	input  sensor_pkg::sensor_frame_u frame,
	input  logic refuse
);
	typedef enum logic [1:0] {m_idle, m_address, m_read} mode_t;

	mode_t mode = m_idle;
	logic scl_q = 1'b1;
	logic line_q = 1'b1;
	logic pull_low = 1'b0;
	// bit slot within the current byte, 9 is the ack slot
	logic [3:0] count = 4'd0;
	logic [1:0] byte_index = 2'd0;
	logic [7:0] shift_in = 8'd0;
	logic line;

	// wired and of master and slave
	assign line = (sda_oe ? sda_out : 1'b1) & ~pull_low;
	assign sda_in = line;

	// sampled half a clock after the master moves
	always @(negedge clock) begin
		scl_q <= scl;
		line_q <= line;
		if (scl && scl_q && line_q && !line) begin
			// start or repeated start
			mode <= m_address;
			count <= 4'd0;
		end else if (scl && scl_q && !line_q && line) begin
			mode <= m_idle;
			pull_low <= 1'b0;
		end else if (scl && !scl_q) begin
			count <= count + 4'd1;
			if (mode == m_address && count < 4'd8)
				shift_in <= {shift_in[6:0], line};
		end else if (!scl && scl_q) begin
			case (mode)
				m_address: begin
					if (count == 4'd8) begin
						pull_low <= (shift_in[7:1] == address) && !refuse;
					end else if (count == 4'd9) begin
						// read direction acked, put out the first bit
						if (pull_low && shift_in[0]) begin
							mode <= m_read;
							count <= 4'd0;
							byte_index <= 2'd0;
							pull_low <= ~frame.bytes[3][7];
						end else begin
							mode <= m_idle;
							pull_low <= 1'b0;
						end
					end
				end
				m_read: begin
					if (count < 4'd8) begin
						pull_low <= ~frame.bytes[2'd3 - byte_index][3'd7 - count[2:0]];
					end else if (count == 4'd8) begin
						// master owns the ack slot
						pull_low <= 1'b0;
					end else begin
						count <= 4'd0;
						byte_index <= byte_index + 2'd1;
						if (byte_index == 2'd3)
							mode <= m_idle;
						else
							pull_low <= ~frame.bytes[2'd2 - byte_index][7];
					end
				end
				default: begin
				end
			endcase
		end
	end
endmodule

// File: bench/hygrometer_props.sv
/* concurrent checks on the sample and byte handshakes and the i2c bus */
`timescale 1ns/100ps

module hygrometer_props (
	input logic clock,
	input logic uart_resetb,
	input logic req,
	input logic ack,
	input logic tx_req,
	input link_pkg::ascii_t tx_char,
	input logic scl,
	input logic sda_oe,
	input link_pkg::i2c_phase_t phase
);
	// new sample request only after ack has dropped
	assert property (@(posedge clock) disable iff (!uart_resetb) $rose(req) |-> !ack)
		else $error("sample req rose while ack was still high");

	// character held for the whole request
	assert property (@(posedge clock) disable iff (!uart_resetb)
		(tx_req && $past(tx_req)) |-> $stable(tx_char))
		else $error("tx_char changed while tx_req was high");

	// sda moves under high scl only for start and stop
	assert property (@(posedge clock) disable iff (!uart_resetb)
		(scl && $past(scl) && $changed(sda_oe)) |->
		((phase == link_pkg::phase_start && sda_oe) ||
		(phase == link_pkg::phase_stop && !sda_oe)))
		else $error("sda changed while scl was high outside start or stop");
endmodule

// File: bench/hygrometer_tb.sv
/* hygrometer testbench: stimulus table, sensor model, uart line receiver,
   compare tasks and timeout */
`timescale 1ns/100ps

module hygrometer_tb;
	localparam int row_count = 8;
	localparam int bit_clocks = 8;
	// per line about 950 clocks of i2c and 1300 of uart
	localparam int cycle_limit = row_count * 4000;

	logic clock;
	logic uart_resetb;
	logic scl;
	logic sda_out;
	logic sda_oe;
	logic sda_in;
	logic tx;
	logic sensor_fault;
	sensor_pkg::sensor_frame_u model_frame;
	logic model_refuse;
	int cycle_count;

	// one row per report line
	sensor_pkg::sensor_frame_u row_frame [row_count];
	logic row_refuse [row_count];
	link_pkg::ascii_t row_text [row_count][16];
	int row_length [row_count];

	hygrometer_top #(
		.i2c_quarter_clocks(4),
		.clocks_per_bit(bit_clocks)
	) i_hygrometer_top (
		.clock(clock), .uart_resetb(uart_resetb), .scl(scl), .sda_out(sda_out),
		.sda_oe(sda_oe), .sda_in(sda_in), .tx(tx), .sensor_fault(sensor_fault)
	);

	hih_sensor_model i_hih_sensor_model (
		.clock(clock), .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe),
		.sda_in(sda_in), .frame(model_frame), .refuse(model_refuse)
	);

	bind hygrometer_top hygrometer_props i_hygrometer_props (
		.clock(clock), .uart_resetb(uart_resetb), .req(smp_link.req), .ack(smp_link.ack),
		.tx_req(tx_req), .tx_char(tx_char), .scl(scl), .sda_oe(sda_oe),
		.phase(i_i2c_sensor_reader.phase)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			abort_run($sformatf("timeout after %0d cycles, report lines incomplete", cycle_count));
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_char(input int row, input int pos,
		input link_pkg::ascii_t got, input link_pkg::ascii_t expected);
		if (got !== expected)
			abort_run($sformatf("MISMATCH tx line %0d char %0d: got 0x%h expected 0x%h",
				row, pos, got, expected));
	endtask

	task automatic compare_fault(input int row, input logic got, input logic expected);
		if (got !== expected)
			abort_run($sformatf("MISMATCH sensor_fault line %0d: got 0x%h expected 0x%h",
				row, got, expected));
	endtask

	// digit at a decimal place, 0 is the units
	function automatic link_pkg::ascii_t decimal_digit(input int value, input int place);
		int rest;
		rest = value;
		for (int i = 0; i < place; i++)
			rest = rest / 10;
		return link_pkg::ascii_t'(48 + rest % 10);
	endfunction

	task automatic predict_line(input int row);
		int humidity;
		int temp_sum;
		int temp_mag;
		logic [13:0] raw_h;
		logic [13:0] raw_t;
		raw_h = row_frame[row].fields.humidity;
		raw_t = row_frame[row].fields.temperature;
		humidity = (int'(raw_h) * 100) >> 14;
		temp_sum = int'(raw_t[13:7]) + int'(raw_t[13:9]);
		temp_mag = (temp_sum >= 40) ? temp_sum - 40 : 40 - temp_sum;
		// sequence number equals the line index
		for (int pos = 0; pos < 5; pos++)
			row_text[row][pos] = decimal_digit(row, 4 - pos);
		row_text[row][5] = 8'h20;
		if (row_refuse[row]) begin
			row_text[row][6] = 8'h45;
			row_text[row][7] = 8'h52;
			row_text[row][8] = 8'h52;
			row_text[row][9] = 8'h0d;
			row_text[row][10] = 8'h0a;
			row_length[row] = 11;
		end else begin
			for (int pos = 0; pos < 3; pos++) begin
				row_text[row][6 + pos] = decimal_digit(humidity, 2 - pos);
				row_text[row][11 + pos] = decimal_digit(temp_mag, 2 - pos);
			end
			row_text[row][9] = 8'h20;
			row_text[row][10] = (temp_sum >= 40) ? 8'h2b : 8'h2d;
			row_text[row][14] = 8'h0d;
			row_text[row][15] = 8'h0a;
			row_length[row] = 16;
		end
	endtask

	task automatic build_table();
		sensor_pkg::sensor_fields_t fields;
		for (int row = 0; row < row_count; row++) begin
			fields.status = sensor_pkg::sensor_status_t'(2'($urandom));
			fields.humidity = 14'($urandom);
			fields.temperature = 14'($urandom);
			fields.unused = 2'($urandom);
			row_refuse[row] = (row == 3);
			case (row)
				0: fields = '0;
				1: begin
					fields.humidity = 14'h3fff;
					fields.temperature = 14'h3fff;
				end
				// 32 + 8 lands on the offset exactly
				2: begin
					fields.humidity = 14'd8192;
					fields.temperature = 14'd4096;
				end
				default: begin
				end
			endcase
			row_frame[row].fields = fields;
			predict_line(row);
		end
	endtask

	task automatic load_row(input int row);
		@(posedge clock);
		model_frame <= row_frame[row];
		model_refuse <= row_refuse[row];
	endtask

	// 8n1 receiver, sampled at mid-bit on the falling clock
	task automatic receive_char(output link_pkg::ascii_t received);
		@(negedge clock);
		while (tx !== 1'b0)
			@(negedge clock);
		repeat (bit_clocks / 2) @(negedge clock);
		if (tx !== 1'b0)
			abort_run("uart start bit did not stay low up to mid-bit");
		for (int b = 0; b < 8; b++) begin
			repeat (bit_clocks) @(negedge clock);
			received[b] = tx;
		end
		repeat (bit_clocks) @(negedge clock);
		if (tx !== 1'b1)
			abort_run("uart stop bit was not high");
	endtask

	task automatic receive_line(input int row);
		link_pkg::ascii_t received;
		for (int pos = 0; pos < row_length[row]; pos++) begin
			receive_char(received);
			compare_char(row, pos, received, row_text[row][pos]);
		end
	endtask

	initial begin
		clock = 1'b0;
		uart_resetb = 1'b0;
		model_frame = '0;
		model_refuse = 1'b0;
		cycle_count = 0;
		void'($urandom(32'habcf));
		build_table();
		repeat (4) @(posedge clock);
		uart_resetb <= 1'b1;
		// next row goes in while the line feed is still on the wire
		for (int row = 0; row < row_count; row++) begin
			load_row(row);
			receive_line(row);
			compare_fault(row, sensor_fault, row_refuse[row]);
		end
		$display("TEST PASS");
		$finish;
	end
endmodule

// File: hygrometer_top.f
src/sensor_pkg.sv
src/link_pkg.sv
src/sample_if.sv
src/i2c_sensor_reader.sv
src/bin_to_bcd.sv
src/report_formatter.sv
src/uart_tx.sv
src/hygrometer_top.sv
bench/hih_sensor_model.sv
bench/hygrometer_props.sv
bench/hygrometer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal --top-module hygrometer_tb \
	-f hygrometer_top.f -o hygrometer_sim > build.log 2>&1 &&
	{ ./obj_dir/hygrometer_sim > sim.log 2>&1 || echo "TEST FAIL" >> sim.log; } &&
	! grep -q "TEST FAIL" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: src/bin_to_bcd.sv
/* sequential double dabble, binary to packed bcd */
`timescale 1ns/100ps

module bin_to_bcd #(
	parameter int bcd_bits = 16,
	parameter int bcd_digits = 5
) (
	input  logic clock,
	input  logic uart_resetb,
	input  logic start,
	input  logic [bcd_bits-1:0] binary,
	output logic done,
	output logic [4*bcd_digits-1:0] bcd
);
	localparam int count_bits = $clog2(bcd_bits + 1);

	logic [bcd_bits-1:0] shift_bin;
	logic [4*bcd_digits-1:0] adjusted;
	logic [count_bits-1:0] count;
	logic busy;

	// add three to every digit of five or more
	always_comb begin
		for (int i = 0; i < bcd_digits; i++) begin
			adjusted[4*i +: 4] = (bcd[4*i +: 4] >= 4'd5) ?
				bcd[4*i +: 4] + 4'd3 : bcd[4*i +: 4];
		end
	end

	// one input bit per cycle, msb first
	always_ff @(posedge clock) begin
		if (start) begin
			shift_bin <= binary;
			bcd <= '0;
		end else if (busy) begin
			bcd <= {adjusted[4*bcd_digits-2:0], shift_bin[bcd_bits-1]};
			shift_bin <= shift_bin << 1;
		end
	end

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				count <= count_bits'(bcd_bits);
				busy <= 1'b1;
			end else if (busy) begin
				count <= count - 1'b1;
				// last shift lands now, so done comes next cycle
				if (count == count_bits'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end
endmodule

// File: src/hygrometer_top.sv
/* hygrometer top: i2c reader, report formatter, uart transmitter */
`timescale 1ns/100ps

module hygrometer_top #(
	parameter logic [6:0] sensor_address = 7'h27,
	parameter int i2c_quarter_clocks = 32,
	parameter int clocks_per_bit = 104,
	parameter int bcd_bits = 16,
	parameter int bcd_digits = 5
) (
	input  logic clock,
	input  logic uart_resetb,
	output logic scl,
	output logic sda_out,
	output logic sda_oe,
	input  logic sda_in,
	output logic tx,
	output logic sensor_fault
);
	// byte link to the transmitter
	logic tx_req;
	logic tx_ack;
	link_pkg::ascii_t tx_char;

	sample_if smp_link ();

	i2c_sensor_reader #(
		.sensor_address(sensor_address),
		.i2c_quarter_clocks(i2c_quarter_clocks)
	) i_i2c_sensor_reader (
		.clock(clock), .uart_resetb(uart_resetb), .scl(scl), .sda_out(sda_out),
		.sda_oe(sda_oe), .sda_in(sda_in), .smp(smp_link.reader)
	);

	report_formatter #(.bcd_bits(bcd_bits), .bcd_digits(bcd_digits)) i_report_formatter (
		.clock(clock), .uart_resetb(uart_resetb), .smp(smp_link.formatter),
		.tx_req(tx_req), .tx_ack(tx_ack), .tx_char(tx_char), .sensor_fault(sensor_fault)
	);

	uart_tx #(.clocks_per_bit(clocks_per_bit)) i_uart_tx (
		.clock(clock), .uart_resetb(uart_resetb), .tx_req(tx_req),
		.tx_ack(tx_ack), .tx_char(tx_char), .tx(tx)
	);
endmodule

// File: src/i2c_sensor_reader.sv
/* i2c master: measurement request, then four-byte frame read */
`timescale 1ns/100ps

module i2c_sensor_reader #(
	parameter logic [6:0] sensor_address = 7'h27,
	parameter int i2c_quarter_clocks = 32
) (
	input  logic clock,
	input  logic uart_resetb,
	output logic scl,
	output logic sda_out,
	output logic sda_oe,
	input  logic sda_in,
	sample_if.reader smp
);
	localparam int timer_bits = $clog2(i2c_quarter_clocks);

	link_pkg::i2c_phase_t phase;
	logic [timer_bits-1:0] timer;
	logic [1:0] quarter;
	logic quarter_tick;
	logic [2:0] bit_count;
	logic [1:0] byte_count;
	// second address pass is the read
	logic read_mode;
	// stop after the write, then start again
	logic restart;
	logic sda_drive;
	logic [7:0] address_byte;
	logic [7:0] shift_byte;
	sensor_pkg::sensor_frame_u frame_r;
	logic ack_r;
	logic nacked_r;

	assign quarter_tick = (timer == timer_bits'(i2c_quarter_clocks - 1));
	assign address_byte = {sensor_address, read_mode};

	// scl high in idle and start, else high in quarters 2 and 3
	assign scl = (phase == link_pkg::phase_idle || phase == link_pkg::phase_start) ?
		1'b1 : quarter[1];
	// open drain, only ever pull low
	assign sda_out = 1'b0;
	assign sda_oe = sda_drive;

	assign smp.ack = ack_r;
	assign smp.nacked = nacked_r;
	assign smp.frame = frame_r;

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			phase <= link_pkg::phase_idle;
			timer <= '0;
			quarter <= '0;
			bit_count <= '0;
			byte_count <= '0;
			read_mode <= 1'b0;
			restart <= 1'b0;
			sda_drive <= 1'b0;
			ack_r <= 1'b0;
			nacked_r <= 1'b0;
		end else if (phase == link_pkg::phase_idle) begin
			timer <= '0;
			quarter <= '0;
			if (ack_r && !smp.req) begin
				ack_r <= 1'b0;
			end else if (smp.req && !ack_r) begin
				phase <= link_pkg::phase_start;
				read_mode <= 1'b0;
				restart <= 1'b0;
				nacked_r <= 1'b0;
			end
		end else if (quarter_tick) begin
			timer <= '0;
			quarter <= quarter + 2'd1;
			case (phase)
				link_pkg::phase_start: begin
					// sda falls with scl high
					if (quarter == 2'd1)
						sda_drive <= 1'b1;
					if (quarter == 2'd3) begin
						phase <= link_pkg::phase_address;
						bit_count <= 3'd7;
					end
				end
				link_pkg::phase_address: begin
					// data moves only while scl is low
					if (quarter == 2'd0)
						sda_drive <= ~address_byte[bit_count];
					if (quarter == 2'd3) begin
						if (bit_count == 3'd0)
							phase <= link_pkg::phase_address_ack;
						else
							bit_count <= bit_count - 3'd1;
					end
				end
				link_pkg::phase_address_ack: begin
					if (quarter == 2'd0)
						sda_drive <= 1'b0;
					// sampled mid high, released line means refusal
					if (quarter == 2'd2)
						nacked_r <= sda_in;
					if (quarter == 2'd3) begin
						if (nacked_r) begin
							phase <= link_pkg::phase_stop;
						end else if (read_mode) begin
							phase <= link_pkg::phase_data;
							bit_count <= 3'd7;
							byte_count <= 2'd0;
						end else begin
							restart <= 1'b1;
							phase <= link_pkg::phase_stop;
						end
					end
				end
				link_pkg::phase_data: begin
					if (quarter == 2'd0)
						sda_drive <= 1'b0;
					if (quarter == 2'd2)
						shift_byte <= {shift_byte[6:0], sda_in};
					if (quarter == 2'd3) begin
						if (bit_count == 3'd0)
							phase <= link_pkg::phase_data_ack;
						else
							bit_count <= bit_count - 3'd1;
					end
				end
				link_pkg::phase_data_ack: begin
					// ack bytes 0 to 2, leave the last one unacked
					if (quarter == 2'd0) begin
						sda_drive <= (byte_count != 2'd3);
						frame_r.bytes[2'd3 - byte_count] <= shift_byte;
					end
					if (quarter == 2'd3) begin
						if (byte_count == 2'd3) begin
							phase <= link_pkg::phase_stop;
						end else begin
							byte_count <= byte_count + 2'd1;
							bit_count <= 3'd7;
							phase <= link_pkg::phase_data;
						end
					end
				end
				link_pkg::phase_stop: begin
					if (quarter == 2'd0)
						sda_drive <= 1'b1;
					// sda rises with scl high
					if (quarter == 2'd2)
						sda_drive <= 1'b0;
					if (quarter == 2'd3) begin
						if (restart) begin
							restart <= 1'b0;
							read_mode <= 1'b1;
							phase <= link_pkg::phase_start;
						end else begin
							phase <= link_pkg::phase_idle;
							ack_r <= 1'b1;
						end
					end
				end
				default: phase <= link_pkg::phase_idle;
			endcase
		end else begin
			timer <= timer + 1'b1;
		end
	end
endmodule

// File: src/link_pkg.sv
/* ascii character type, report line layout and i2c phases */
package link_pkg;

	typedef logic [7:0] ascii_t;

	// normal and error line lengths, cr lf included
	localparam int line_length = 16;
	localparam int error_line_length = 11;
	localparam int sequence_digits = 5;

	localparam ascii_t char_zero = 8'h30;
	localparam ascii_t char_space = 8'h20;
	localparam ascii_t char_plus = 8'h2b;
	localparam ascii_t char_minus = 8'h2d;
	localparam ascii_t char_e = 8'h45;
	localparam ascii_t char_r = 8'h52;
	localparam ascii_t char_cr = 8'h0d;
	localparam ascii_t char_lf = 8'h0a;

	// sequencer states, each one stepped in quarter bits
	typedef enum logic [2:0] {
		phase_idle, phase_start, phase_address, phase_address_ack,
		phase_data, phase_data_ack, phase_stop
	} i2c_phase_t;

endpackage

// File: src/report_formatter.sv
/* sample fetch, scaling, bcd conversion and ascii line output */
`timescale 1ns/100ps

module report_formatter #(
	parameter int bcd_bits = 16,
	parameter int bcd_digits = 5
) (
	input  logic clock,
	input  logic uart_resetb,
	sample_if.formatter smp,
	output logic tx_req,
	input  logic tx_ack,
	output link_pkg::ascii_t tx_char,
	output logic sensor_fault
);
	typedef enum logic [1:0] {st_request, st_convert, st_send} state_t;

	state_t state;
	sensor_pkg::sensor_frame_u frame_r;
	logic [15:0] seq_count;
	logic [1:0] conv_index;
	logic conv_start;
	logic conv_done;
	logic [bcd_bits-1:0] conv_binary;
	logic [4*bcd_digits-1:0] conv_bcd;
	logic [4*bcd_digits-1:0] seq_digits;
	logic [11:0] hum_digits;
	logic [11:0] temp_digits;
	logic [3:0] char_index;
	logic last_char;
	logic [13:0] raw_hum;
	logic [13:0] raw_temp;
	logic [20:0] hum_product;
	logic [6:0] hum_percent;
	logic [7:0] temp_sum;
	logic [7:0] temp_mag;
	logic temp_negative;

	function automatic link_pkg::ascii_t digit_char(input logic [3:0] digit);
		return link_pkg::char_zero + link_pkg::ascii_t'(digit);
	endfunction

	assign raw_hum = frame_r.fields.humidity;
	assign raw_temp = frame_r.fields.temperature;
	// times 100 as 64 + 32 + 4
	assign hum_product = {1'b0, raw_hum, 6'b0} + {2'b0, raw_hum, 5'b0} + {5'b0, raw_hum, 2'b0};
	assign hum_percent = 7'(hum_product >> sensor_pkg::humidity_shift);
	// roughly raw / 100, minus the offset
	assign temp_sum = {1'b0, raw_temp[13:7]} + {3'b0, raw_temp[13:9]};
	assign temp_negative = temp_sum < sensor_pkg::temp_offset;
	assign temp_mag = temp_negative ? sensor_pkg::temp_offset - temp_sum :
		temp_sum - sensor_pkg::temp_offset;

	// one converter, three values in turn
	always_comb begin
		case (conv_index)
			2'd0: conv_binary = bcd_bits'(seq_count);
			2'd1: conv_binary = bcd_bits'(hum_percent);
			default: conv_binary = bcd_bits'(temp_mag);
		endcase
	end

	bin_to_bcd #(.bcd_bits(bcd_bits), .bcd_digits(bcd_digits)) i_bin_to_bcd (
		.clock(clock), .uart_resetb(uart_resetb), .start(conv_start),
		.binary(conv_binary), .done(conv_done), .bcd(conv_bcd)
	);

	assign last_char = (char_index == (sensor_fault ? 4'(link_pkg::error_line_length - 1) :
		4'(link_pkg::line_length - 1)));

	// character at the current line position
	always_comb begin
		tx_char = link_pkg::char_lf;
		if (char_index < 4'(link_pkg::sequence_digits)) begin
			tx_char = digit_char(seq_digits[4*(link_pkg::sequence_digits - 1 - char_index) +: 4]);
		end else if (sensor_fault) begin
			case (char_index)
				4'd5: tx_char = link_pkg::char_space;
				4'd6: tx_char = link_pkg::char_e;
				4'd7, 4'd8: tx_char = link_pkg::char_r;
				4'd9: tx_char = link_pkg::char_cr;
				default: tx_char = link_pkg::char_lf;
			endcase
		end else begin
			case (char_index)
				4'd5, 4'd9: tx_char = link_pkg::char_space;
				4'd6: tx_char = digit_char(hum_digits[11:8]);
				4'd7: tx_char = digit_char(hum_digits[7:4]);
				4'd8: tx_char = digit_char(hum_digits[3:0]);
				4'd10: tx_char = temp_negative ? link_pkg::char_minus : link_pkg::char_plus;
				4'd11: tx_char = digit_char(temp_digits[11:8]);
				4'd12: tx_char = digit_char(temp_digits[7:4]);
				4'd13: tx_char = digit_char(temp_digits[3:0]);
				4'd14: tx_char = link_pkg::char_cr;
				default: tx_char = link_pkg::char_lf;
			endcase
		end
	end

	// captured sample and stored digits
	always_ff @(posedge clock) begin
		if (state == st_request && smp.req && smp.ack)
			frame_r <= smp.frame;
		if (conv_done) begin
			case (conv_index)
				2'd0: seq_digits <= conv_bcd;
				2'd1: hum_digits <= conv_bcd[11:0];
				default: temp_digits <= conv_bcd[11:0];
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			state <= st_request;
			smp.req <= 1'b0;
			tx_req <= 1'b0;
			seq_count <= '0;
			conv_index <= '0;
			conv_start <= 1'b0;
			char_index <= '0;
			sensor_fault <= 1'b0;
		end else begin
			conv_start <= 1'b0;
			case (state)
				st_request: begin
					if (!smp.req && !smp.ack)
						smp.req <= 1'b1;
					if (smp.req && smp.ack) begin
						smp.req <= 1'b0;
						sensor_fault <= smp.nacked;
						conv_index <= 2'd0;
						conv_start <= 1'b1;
						state <= st_convert;
					end
				end
				st_convert: begin
					// error lines need only the sequence number
					if (conv_done) begin
						if (conv_index == 2'd2 || sensor_fault) begin
							char_index <= '0;
							state <= st_send;
						end else begin
							conv_index <= conv_index + 2'd1;
							conv_start <= 1'b1;
						end
					end
				end
				default: begin
					if (!tx_req && !tx_ack)
						tx_req <= 1'b1;
					if (tx_req && tx_ack) begin
						tx_req <= 1'b0;
						if (last_char) begin
							seq_count <= seq_count + 16'd1;
							state <= st_request;
						end else begin
							char_index <= char_index + 4'd1;
						end
					end
				end
			endcase
		end
	end
endmodule

// File: src/sample_if.sv
/* four-phase req/ack link carrying one sensor frame */
`timescale 1ns/100ps

interface sample_if;
	// formatter asks for a reading
	logic req;
	// reader has finished the bus transaction
	logic ack;
	sensor_pkg::sensor_frame_u frame;
	// address was refused, frame not valid
	logic nacked;

	modport reader (input req, output ack, output frame, output nacked);
	modport formatter (output req, input ack, input frame, input nacked);
endinterface

// File: src/sensor_pkg.sv
/* sensor frame layout, status codes and scaling constants
   for the humidity and temperature sensor */
package sensor_pkg;

	// two-bit status field at the top of the frame
	typedef enum logic [1:0] {
		status_normal     = 2'b00,
		status_stale      = 2'b01,
		status_command    = 2'b10,
		status_diagnostic = 2'b11
	} sensor_status_t;

	// field view, msb first as it comes off the bus
	typedef struct packed {
		sensor_status_t status;
		logic [13:0]    humidity;
		logic [13:0]    temperature;
		logic [1:0]     unused;
	} sensor_fields_t;

	// same 32 bits seen as bytes or as fields
	typedef union packed {
		logic [3:0][7:0] bytes;
		sensor_fields_t  fields;
	} sensor_frame_u;

	// raw * 100 >> 14 gives percent
	localparam int humidity_shift = 14;
	// subtracted from the approximate temperature sum
	localparam logic [7:0] temp_offset = 8'd40;

endpackage

// File: src/uart_tx.sv
/* 8n1 serial transmitter, req/ack byte input */
`timescale 1ns/100ps

module uart_tx #(
	parameter int clocks_per_bit = 104
) (
	input  logic clock,
	input  logic uart_resetb,
	input  logic tx_req,
	output logic tx_ack,
	input  link_pkg::ascii_t tx_char,
	output logic tx
);
	localparam int timer_bits = $clog2(clocks_per_bit);

	logic [timer_bits-1:0] timer;
	logic [3:0] bit_count;
	logic active;
	// stop, data lsb first, start
	logic [9:0] shift_reg;

	// line idles high
	assign tx = active ? shift_reg[0] : 1'b1;

	always_ff @(posedge clock) begin
		if (!active && !tx_ack && tx_req)
			shift_reg <= {1'b1, tx_char, 1'b0};
		else if (active && timer == timer_bits'(clocks_per_bit - 1))
			shift_reg <= {1'b1, shift_reg[9:1]};
	end

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			active <= 1'b0;
			tx_ack <= 1'b0;
			timer <= '0;
			bit_count <= '0;
		end else if (active) begin
			if (timer == timer_bits'(clocks_per_bit - 1)) begin
				timer <= '0;
				// frame ends after the stop bit
				if (bit_count == 4'd9)
					active <= 1'b0;
				else
					bit_count <= bit_count + 4'd1;
			end else begin
				timer <= timer + 1'b1;
			end
		end else if (tx_ack) begin
			// hold ack until the request is gone
			if (!tx_req)
				tx_ack <= 1'b0;
		end else if (tx_req) begin
			active <= 1'b1;
			tx_ack <= 1'b1;
			timer <= '0;
			bit_count <= '0;
		end
	end
endmodule
